// ==== common/valu_pkg.sv ====
/*
 * Vector ALU lane package.
 * Datapath widths, instruction field types, opcode and element-width
 * encodings, and the helpers that count elements per 64-bit word.
 */
package valu_pkg;

  // Datapath geometry
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;
  // Instruction ids in flight across the whole machine
  localparam int unsigned NrVInsn  = 8;

  typedef logic [ElenBits-1:0]        elen_t;
  typedef logic [StrbBits-1:0]        strb_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [15:0]                vlen_t;
  typedef logic [4:0]                 vreg_t;
  // Word address into this lane's slice of the register file
  typedef logic [11:0]                vaddr_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Integer operations of this lane
  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4
  } valu_op_e;

  // Elements that fit in one 64-bit word
  function automatic logic [3:0] elems_per_word(vew_e vsew);
    return 4'd8 >> vsew;
  endfunction

  // Byte enables for the lowest cnt elements of a word
  function automatic strb_t be_for(logic [3:0] cnt, vew_e vsew);
    strb_t be;
    be = '0;
    for (int unsigned b = 0; b < StrbBits; b++) begin
      // Byte b belongs to element b >> vsew
      if ((b >> vsew) < cnt) begin
        be[b] = 1'b1;
      end
    end
    return be;
  endfunction

endpackage

// ==== source/vinsn_queue.sv ====
/*
 * Vector instruction queue.
 * Holds accepted instructions in a ring, presents the oldest unissued one
 * to the datapath and counts down committed elements, pulsing the
 * instruction's done bit when its last word is granted.
 */
module vinsn_queue import valu_pkg::*; #(
  parameter int unsigned VInsnQueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // New instruction
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  valu_op_e           op_i,
  input  vew_e               vsew_i,
  input  vlen_t              vl_i,
  input  vreg_t              vd_i,
  input  vid_t               id_i,
  input  logic               vm_i,
  input  logic               use_scalar_i,
  input  elen_t              scalar_i,
  input  logic               use_vs1_i,
  // Issue side
  output logic               issue_valid_o,
  output valu_op_e           issue_op_o,
  output vew_e               issue_vsew_o,
  output vlen_t              issue_vl_o,
  output vreg_t              issue_vd_o,
  output vid_t               issue_id_o,
  output logic               issue_vm_o,
  output logic               issue_use_scalar_o,
  output elen_t              issue_scalar_o,
  output logic               issue_use_vs1_o,
  input  logic               issue_done_i,
  // Commit side
  input  logic               commit_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  localparam int unsigned PtrW = (VInsnQueueDepth > 1) ? $clog2(VInsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(VInsnQueueDepth + 1);

  // Instruction storage, one array per field
  valu_op_e op_q         [VInsnQueueDepth];
  vew_e     vsew_q       [VInsnQueueDepth];
  vlen_t    vl_q         [VInsnQueueDepth];
  vreg_t    vd_q         [VInsnQueueDepth];
  vid_t     id_q         [VInsnQueueDepth];
  logic     vm_q         [VInsnQueueDepth];
  logic     use_scalar_q [VInsnQueueDepth];
  elen_t    scalar_q     [VInsnQueueDepth];
  logic     use_vs1_q    [VInsnQueueDepth];

  // Ring pointers for the three phases
  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue / waiting to commit
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;
  // Remaining elements of the committing instruction
  vlen_t           commit_elems_d, commit_elems_q;
  logic            accept, commit_last;
  logic [3:0]      commit_epw;

  function automatic logic [PtrW-1:0] next_pnt(logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(VInsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Full once every slot holds an uncommitted instruction
  assign insn_ready_o = (commit_cnt_q != CntW'(VInsnQueueDepth));
  assign accept       = insn_valid_i & insn_ready_o;

  assign issue_valid_o      = (issue_cnt_q != '0);
  assign issue_op_o         = op_q[issue_pnt_q];
  assign issue_vsew_o       = vsew_q[issue_pnt_q];
  assign issue_vl_o         = vl_q[issue_pnt_q];
  assign issue_vd_o         = vd_q[issue_pnt_q];
  assign issue_id_o         = id_q[issue_pnt_q];
  assign issue_vm_o         = vm_q[issue_pnt_q];
  assign issue_use_scalar_o = use_scalar_q[issue_pnt_q];
  assign issue_scalar_o     = scalar_q[issue_pnt_q];
  assign issue_use_vs1_o    = use_vs1_q[issue_pnt_q];

  assign commit_epw = elems_per_word(vsew_q[commit_pnt_q]);

  always_comb begin
    commit_elems_d = commit_elems_q;
    commit_last    = 1'b0;
    vinsn_done_o   = '0;
    if (commit_i) begin
      // Last word may hold fewer elements, so clamp at zero
      commit_elems_d = (commit_elems_q > vlen_t'(commit_epw)) ?
                       commit_elems_q - vlen_t'(commit_epw) : '0;
      if ((commit_cnt_q != '0) && (commit_elems_d == '0)) begin
        commit_last                   = 1'b1;
        vinsn_done_o[id_q[commit_pnt_q]] = 1'b1;
        // Next instruction in line starts its countdown
        if (commit_cnt_q > CntW'(1)) begin
          commit_elems_d = vl_q[next_pnt(commit_pnt_q)];
        end
      end
    end
    // Commit side was (or just became) empty
    if (accept && ((commit_cnt_q == '0) || (commit_last && commit_cnt_q == CntW'(1)))) begin
      commit_elems_d = vl_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= op_i;
      vsew_q[accept_pnt_q]       <= vsew_i;
      vl_q[accept_pnt_q]         <= vl_i;
      vd_q[accept_pnt_q]         <= vd_i;
      id_q[accept_pnt_q]         <= id_i;
      vm_q[accept_pnt_q]         <= vm_i;
      use_scalar_q[accept_pnt_q] <= use_scalar_i;
      scalar_q[accept_pnt_q]     <= scalar_i;
      use_vs1_q[accept_pnt_q]    <= use_vs1_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q   <= '0;
      issue_pnt_q    <= '0;
      commit_pnt_q   <= '0;
      issue_cnt_q    <= '0;
      commit_cnt_q   <= '0;
      commit_elems_q <= '0;
    end else begin
      if (accept)       accept_pnt_q <= next_pnt(accept_pnt_q);
      if (issue_done_i) issue_pnt_q  <= next_pnt(issue_pnt_q);
      if (commit_last)  commit_pnt_q <= next_pnt(commit_pnt_q);
      issue_cnt_q    <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q   <= commit_cnt_q + CntW'(accept) - CntW'(commit_last);
      commit_elems_q <= commit_elems_d;
    end
  end

endmodule

// ==== simd_alu/simd_alu.sv ====
/*
 * SIMD integer ALU.
 * Works on one 64-bit word as 8, 4, 2 or 1 elements. The scalar operand
 * is replicated to the element width, and the adder chain is cut at
 * every element boundary so no carry or borrow leaks into the next one.
 */
module simd_alu import valu_pkg::*; (
  input  valu_op_e op_i,
  input  vew_e     vsew_i,
  input  logic     use_scalar_i,
  input  elen_t    scalar_i,
  input  elen_t    operand_a_i,
  input  elen_t    operand_b_i,
  output elen_t    result_o
);

  elen_t             scalar_rep;
  elen_t             opa;
  elen_t             addend;
  elen_t             sum;
  logic              is_sub;
  logic              cin;
  logic [StrbBits:0] carry;
  // Bytes per element, minus one, used to spot element boundaries
  logic [3:0]        elem_bytes_m1;

  // Replicate scalar across the word
  always_comb begin
    case (vsew_i)
      EW8:     scalar_rep = {8{scalar_i[7:0]}};
      EW16:    scalar_rep = {4{scalar_i[15:0]}};
      EW32:    scalar_rep = {2{scalar_i[31:0]}};
      default: scalar_rep = scalar_i;
    endcase
  end

  // First operand is vs1 or the scalar
  assign opa = use_scalar_i ? scalar_rep : operand_a_i;

  assign elem_bytes_m1 = (4'd1 << vsew_i) - 4'd1;

  // Byte-sliced adder
  // vsub computes vs2 - vs1 as vs2 + ~vs1 + 1
  always_comb begin
    is_sub = (op_i == VSUB);
    addend = is_sub ? ~opa : opa;
    carry  = '0;
    sum    = '0;
    cin    = 1'b0;
    for (int b = 0; b < StrbBits; b++) begin
      // Lowest byte of an element restarts the chain
      if ((4'(b) & elem_bytes_m1) == 4'd0) begin
        cin = is_sub;
      end else begin
        cin = carry[b];
      end
      {carry[b+1], sum[8*b +: 8]} = {1'b0, operand_b_i[8*b +: 8]} +
                                    {1'b0, addend[8*b +: 8]} + 9'(cin);
    end
  end

  // Result select
  always_comb begin
    case (op_i)
      VADD,
      VSUB:    result_o = sum;
      VAND:    result_o = operand_b_i & opa;
      VOR:     result_o = operand_b_i | opa;
      VXOR:    result_o = operand_b_i ^ opa;
      default: result_o = '0;
    endcase
  end

endmodule

// ==== source/elem_seq.sv ====
/*
 * Issue-side element sequencer.
 * Decides when a word can fire, acknowledges its operands and mask,
 * and produces the word's register-file address and byte enables
 * while counting down the elements left to issue.
 */
module elem_seq import valu_pkg::*; #(
  parameter int unsigned VregWords = 32
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Issuing instruction
  input  logic   issue_valid_i,
  input  vew_e   issue_vsew_i,
  input  vlen_t  issue_vl_i,
  input  vreg_t  issue_vd_i,
  input  logic   issue_vm_i,
  input  logic   issue_use_vs1_i,
  // Operand and mask sources
  input  logic   operand_a_valid_i,
  input  logic   operand_b_valid_i,
  output logic   operand_a_ready_o,
  output logic   operand_b_ready_o,
  input  strb_t  mask_i,
  input  logic   mask_valid_i,
  output logic   mask_ready_o,
  // Result queue back-pressure
  input  logic   rq_full_i,
  // Per-word control
  output logic   word_fire_o,
  output logic   issue_done_o,
  output vaddr_t word_addr_o,
  output strb_t  word_be_o
);

  // Remaining count, valid once the instruction has fired its first word
  vlen_t      remaining_q;
  logic       loaded_q;
  vlen_t      remaining, remaining_next, done_elems;
  logic [3:0] epw, elem_cnt;
  logic [1:0] shamt;

  // Fresh instruction reads vl directly
  assign remaining = loaded_q ? remaining_q : issue_vl_i;
  assign epw       = elems_per_word(issue_vsew_i);
  assign elem_cnt  = (remaining < vlen_t'(epw)) ? remaining[3:0] : epw;

  assign remaining_next = remaining - vlen_t'(elem_cnt);

  // Fire needs operands, mask if masked, and room in the result queue
  assign word_fire_o = issue_valid_i & ~rq_full_i &
                       (operand_a_valid_i | ~issue_use_vs1_i) &
                       operand_b_valid_i &
                       (mask_valid_i | issue_vm_i);

  assign operand_a_ready_o = word_fire_o & issue_use_vs1_i;
  assign operand_b_ready_o = word_fire_o;
  assign mask_ready_o      = word_fire_o & ~issue_vm_i;
  assign issue_done_o      = word_fire_o & (remaining_next == '0);

  // Word index = elements done / elements per word
  assign done_elems  = issue_vl_i - remaining;
  assign shamt       = 2'd3 - issue_vsew_i;
  assign word_addr_o = vaddr_t'(issue_vd_i) * vaddr_t'(VregWords) +
                       vaddr_t'(done_elems >> shamt);

  // Tail elements off, masked elements off when vm is low
  assign word_be_o = be_for(elem_cnt, issue_vsew_i) &
                     (issue_vm_i ? {StrbBits{1'b1}} : mask_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
      loaded_q    <= 1'b0;
    end else if (word_fire_o) begin
      remaining_q <= remaining_next;
      // Next instruction reloads from its own vl
      loaded_q    <= ~issue_done_o;
    end
  end

endmodule

// ==== source/result_queue.sv ====
/*
 * Result queue.
 * Stores each fired word together with its address, byte enables and
 * id, presents the oldest entry as a register-file request and frees
 * it on grant, reporting every granted word as a commit.
 */
module result_queue import valu_pkg::*; #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Write side
  input  logic   word_fire_i,
  input  elen_t  wdata_i,
  input  vaddr_t addr_i,
  input  strb_t  be_i,
  input  vid_t   id_i,
  output logic   full_o,
  // Register-file side
  output logic   res_req_o,
  output vaddr_t res_addr_o,
  output elen_t  res_wdata_o,
  output strb_t  res_be_o,
  output vid_t   res_id_o,
  input  logic   res_gnt_i,
  // Granted word, one per cycle at most
  output logic   commit_o
);

  localparam int unsigned PtrW = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(ResultQueueDepth + 1);

  // Entry payload
  elen_t  wdata_q [ResultQueueDepth];
  vaddr_t addr_q  [ResultQueueDepth];
  strb_t  be_q    [ResultQueueDepth];
  vid_t   id_q    [ResultQueueDepth];

  logic [PtrW-1:0] write_pnt_q, read_pnt_q;
  logic [CntW-1:0] cnt_q;
  logic            push, pop;

  function automatic logic [PtrW-1:0] next_pnt(logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full_o = (cnt_q == CntW'(ResultQueueDepth));
  assign push   = word_fire_i & ~full_o;
  assign pop    = res_req_o & res_gnt_i;

  // Oldest entry goes out
  assign res_req_o   = (cnt_q != '0);
  assign res_addr_o  = addr_q[read_pnt_q];
  assign res_wdata_o = wdata_q[read_pnt_q];
  assign res_be_o    = be_q[read_pnt_q];
  assign res_id_o    = id_q[read_pnt_q];
  assign commit_o    = pop;

  always_ff @(posedge clk_i) begin
    if (push) begin
      wdata_q[write_pnt_q] <= wdata_i;
      addr_q[write_pnt_q]  <= addr_i;
      be_q[write_pnt_q]    <= be_i;
      id_q[write_pnt_q]    <= id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_pnt_q <= '0;
      read_pnt_q  <= '0;
      cnt_q       <= '0;
    end else begin
      if (push) begin
        write_pnt_q <= next_pnt(write_pnt_q);
      end
      if (pop) begin
        read_pnt_q <= next_pnt(read_pnt_q);
      end
      // Push and pop in one cycle leave the count alone
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

endmodule

// ==== source/valu_top.sv ====
/*
 * Vector integer ALU lane.
 * Instruction queue feeding an element sequencer and a SIMD ALU side by
 * side; their word and metadata meet in the result queue.
 */
module valu_top import valu_pkg::*; #(
  parameter int unsigned VInsnQueueDepth  = 4,
  parameter int unsigned ResultQueueDepth = 2,
  parameter int unsigned VregWords        = 32
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Instruction
  input  logic               insn_valid_i,
  output logic               insn_ready_o,
  input  valu_op_e           op_i,
  input  vew_e               vsew_i,
  input  vlen_t              vl_i,
  input  vreg_t              vd_i,
  input  vid_t               id_i,
  input  logic               vm_i,
  input  logic               use_scalar_i,
  input  elen_t              scalar_i,
  input  logic               use_vs1_i,
  // Operands and mask
  input  elen_t              operand_a_i,
  input  logic               operand_a_valid_i,
  output logic               operand_a_ready_o,
  input  elen_t              operand_b_i,
  input  logic               operand_b_valid_i,
  output logic               operand_b_ready_o,
  input  strb_t              mask_i,
  input  logic               mask_valid_i,
  output logic               mask_ready_o,
  // Register-file write
  output logic               res_req_o,
  output vaddr_t             res_addr_o,
  output elen_t              res_wdata_o,
  output strb_t              res_be_o,
  output vid_t               res_id_o,
  input  logic               res_gnt_i,
  output logic [NrVInsn-1:0] vinsn_done_o
);

  // Issuing instruction fields
  logic     issue_valid, issue_vm, issue_use_scalar, issue_use_vs1;
  valu_op_e issue_op;
  vew_e     issue_vsew;
  vlen_t    issue_vl;
  vreg_t    issue_vd;
  vid_t     issue_id;
  elen_t    issue_scalar;
  // Word handshake between blocks
  logic     word_fire, issue_done, rq_full, commit;
  vaddr_t   word_addr;
  strb_t    word_be;
  elen_t    alu_result;

  vinsn_queue #(
    .VInsnQueueDepth(VInsnQueueDepth)
  ) i_vinsn_queue (
    .clk_i, .rst_ni, .insn_valid_i, .insn_ready_o,
    .op_i, .vsew_i, .vl_i, .vd_i, .id_i, .vm_i, .use_scalar_i, .scalar_i, .use_vs1_i,
    .issue_valid_o     (issue_valid),
    .issue_op_o        (issue_op),
    .issue_vsew_o      (issue_vsew),
    .issue_vl_o        (issue_vl),
    .issue_vd_o        (issue_vd),
    .issue_id_o        (issue_id),
    .issue_vm_o        (issue_vm),
    .issue_use_scalar_o(issue_use_scalar),
    .issue_scalar_o    (issue_scalar),
    .issue_use_vs1_o   (issue_use_vs1),
    .issue_done_i      (issue_done),
    .commit_i          (commit),
    .vinsn_done_o
  );

  elem_seq #(
    .VregWords(VregWords)
  ) i_elem_seq (
    .clk_i, .rst_ni,
    .issue_valid_i  (issue_valid),
    .issue_vsew_i   (issue_vsew),
    .issue_vl_i     (issue_vl),
    .issue_vd_i     (issue_vd),
    .issue_vm_i     (issue_vm),
    .issue_use_vs1_i(issue_use_vs1),
    .operand_a_valid_i, .operand_b_valid_i, .operand_a_ready_o, .operand_b_ready_o,
    .mask_i, .mask_valid_i, .mask_ready_o,
    .rq_full_i      (rq_full),
    .word_fire_o    (word_fire),
    .issue_done_o   (issue_done),
    .word_addr_o    (word_addr),
    .word_be_o      (word_be)
  );

  simd_alu i_simd_alu (
    .op_i        (issue_op),
    .vsew_i      (issue_vsew),
    .use_scalar_i(issue_use_scalar),
    .scalar_i    (issue_scalar),
    .operand_a_i,
    .operand_b_i,
    .result_o    (alu_result)
  );

  result_queue #(
    .ResultQueueDepth(ResultQueueDepth)
  ) i_result_queue (
    .clk_i, .rst_ni,
    .word_fire_i(word_fire),
    .wdata_i    (alu_result),
    .addr_i     (word_addr),
    .be_i       (word_be),
    .id_i       (issue_id),
    .full_o     (rq_full),
    .res_req_o, .res_addr_o, .res_wdata_o, .res_be_o, .res_id_o, .res_gnt_i,
    .commit_o   (commit)
  );

endmodule

// ==== verif/valu_props.sv ====
/*
 * Handshake properties of the vector ALU lane.
 * Bound to the top level; checks the register-file request, done
 * pulses, operand acknowledges and the ready level after reset.
 */
module valu_props import valu_pkg::*; (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               insn_ready_o,
  input logic               res_req_o,
  input logic               res_gnt_i,
  input vaddr_t             res_addr_o,
  input elen_t              res_wdata_o,
  input vid_t               res_id_o,
  input logic [NrVInsn-1:0] vinsn_done_o,
  input logic               operand_a_valid_i,
  input logic               operand_a_ready_o,
  input logic               operand_b_valid_i,
  input logic               operand_b_ready_o,
  input logic               mask_valid_i,
  input logic               mask_ready_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Ungranted request holds its payload
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_req_o && !res_gnt_i |=> res_req_o && $stable(res_addr_o) &&
                                $stable(res_wdata_o) && $stable(res_id_o))
    else $error("Register-file request dropped or changed before grant");

  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_o))
    else $error("More than one done bit raised in one cycle");

  // Acknowledge only what is offered
  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_a_ready_o |-> operand_a_valid_i)
    else $error("Operand A acknowledged without valid");

  b_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_b_ready_o |-> operand_b_valid_i)
    else $error("Operand B acknowledged without valid");

  m_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mask_ready_o |-> mask_valid_i)
    else $error("Mask acknowledged without valid");

  ready_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> insn_ready_o)
    else $error("Instruction ready low right after reset");

endmodule

bind valu_top valu_props i_valu_props (.*);

// ==== verif/valu_tb.sv ====
/*
 * Directed testbench for the vector ALU lane.
 * Operand, mask and grant models drive the DUT, a monitor collects
 * granted words and done pulses, and a reference model checks them.
 */
module valu_tb import valu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned VregWords = 32;
  // Grant responder modes
  localparam int unsigned GntAlways = 0;
  localparam int unsigned GntRandom = 1;
  localparam int unsigned GntStall  = 2;

  logic clk_i, rst_ni, insn_valid_i, insn_ready_o, vm_i, use_scalar_i, use_vs1_i;
  valu_op_e op_i;
  vew_e vsew_i;
  vlen_t vl_i;
  vreg_t vd_i;
  vid_t id_i, res_id_o;
  elen_t scalar_i, operand_a_i, operand_b_i, res_wdata_o;
  logic operand_a_valid_i, operand_a_ready_o, operand_b_valid_i, operand_b_ready_o;
  strb_t mask_i, res_be_o;
  logic mask_valid_i, mask_ready_o, res_req_o, res_gnt_i;
  vaddr_t res_addr_o;
  logic [NrVInsn-1:0] vinsn_done_o;

  // Stimulus still to be consumed, expected and observed results
  elen_t a_src[$], b_src[$], exp_data[$], got_data[$];
  strb_t m_src[$], exp_be[$], got_be[$];
  vaddr_t exp_addr[$], got_addr[$];
  vid_t exp_id[$], got_id[$], exp_done[$], got_done[$];
  int unsigned gnt_mode = GntAlways;
  integer seed = 32'hb75c;
  int errors = 0;
  int timeouts = 0;

  valu_top #(
    .VInsnQueueDepth (4),
    .ResultQueueDepth(2),
    .VregWords       (VregWords)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Operand and mask sources pop a word on each edge that saw its ready
  initial begin : source_model
    logic take_a, take_b, take_m;
    forever begin
      @(posedge clk_i);
      take_a = operand_a_ready_o;
      take_b = operand_b_ready_o;
      take_m = mask_ready_o;
      #1;
      if (take_a) void'(a_src.pop_front());
      if (take_b) void'(b_src.pop_front());
      if (take_m) void'(m_src.pop_front());
      operand_a_valid_i = (a_src.size() != 0);
      operand_a_i       = (a_src.size() != 0) ? a_src[0] : '0;
      operand_b_valid_i = (b_src.size() != 0);
      operand_b_i       = (b_src.size() != 0) ? b_src[0] : '0;
      mask_valid_i      = (m_src.size() != 0);
      mask_i            = (m_src.size() != 0) ? m_src[0] : '0;
    end
  end

  // Register-file grant
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      case (gnt_mode)
        GntAlways: res_gnt_i = 1'b1;
        GntRandom: res_gnt_i = (($random(seed) & 3) == 0);
        default:   res_gnt_i = 1'b0;
      endcase
    end
  end

  // Granted words and done pulses in arrival order
  always @(posedge clk_i) begin
    if (res_req_o && res_gnt_i) begin
      got_data.push_back(res_wdata_o);
      got_addr.push_back(res_addr_o);
      got_be.push_back(res_be_o);
      got_id.push_back(res_id_o);
    end
    for (int i = 0; i < NrVInsn; i++) begin
      if (vinsn_done_o[i]) got_done.push_back(vid_t'(i));
    end
  end

  // Per-element result, each element computed on its own
  function automatic elen_t ref_word(valu_op_e op, vew_e vsew, logic use_scalar,
                                     elen_t scalar, elen_t a, elen_t b);
    int unsigned w;
    elen_t m, ea, eb, er, res;
    w   = 8 << vsew;
    m   = (w == 64) ? '1 : ((64'd1 << w) - 1);
    res = '0;
    for (int unsigned i = 0; i < 64 / w; i++) begin
      ea = use_scalar ? (scalar & m) : ((a >> (i * w)) & m);
      eb = (b >> (i * w)) & m;
      case (op)
        VADD:    er = eb + ea;
        VSUB:    er = eb - ea;
        VAND:    er = eb & ea;
        VOR:     er = eb | ea;
        default: er = eb ^ ea;
      endcase
      res = res | ((er & m) << (i * w));
    end
    return res;
  endfunction

  // Byte enables of the first cnt elements
  function automatic strb_t ref_be(vew_e vsew, int unsigned cnt);
    strb_t be;
    be = '0;
    for (int unsigned k = 0; k < cnt * (1 << vsew); k++) begin
      be[k] = 1'b1;
    end
    return be;
  endfunction

  task automatic check_word(string name, elen_t exp, elen_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: wdata expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_be(string name, strb_t exp, strb_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: be expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, vaddr_t exp, vaddr_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: addr expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_id(string name, vid_t exp, vid_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: id expected %0d actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: flag expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  // Hold the instruction until an edge sees ready
  task automatic send_insn(valu_op_e op, vew_e vsew, vlen_t vl, vreg_t vd, vid_t id,
                           logic vm, logic use_scalar, elen_t scalar);
    int unsigned t;
    logic acc;
    insn_valid_i = 1'b1;
    op_i         = op;
    vsew_i       = vsew;
    vl_i         = vl;
    vd_i         = vd;
    id_i         = id;
    vm_i         = vm;
    use_scalar_i = use_scalar;
    scalar_i     = scalar;
    use_vs1_i    = ~use_scalar;
    t = 0;
    do begin
      @(posedge clk_i);
      acc = insn_ready_o;
      #1;
      t++;
    end while (!acc && t < 200);
    if (!acc) begin
      $display("Timeout: instruction %0d was never accepted", id);
      timeouts++;
    end
    insn_valid_i = 1'b0;
  endtask

  // Queue operands and expected words for one instruction, then send it
  task automatic run_insn(valu_op_e op, vew_e vsew, vlen_t vl, vreg_t vd, vid_t id,
                          logic vm, logic use_scalar, elen_t scalar, elen_t b_keep);
    int unsigned epw, left, word;
    elen_t a, b;
    strb_t m, be;
    epw  = 8 >> vsew;
    left = vl;
    word = 0;
    while (left > 0) begin
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)} & b_keep;
      m = strb_t'($random(seed));
      if (!use_scalar) a_src.push_back(a);
      b_src.push_back(b);
      be = ref_be(vsew, (left < epw) ? left : epw);
      // Masked words also need a mask beat
      if (!vm) begin
        m_src.push_back(m);
        be = be & m;
      end
      exp_data.push_back(ref_word(op, vsew, use_scalar, scalar, a, b));
      exp_addr.push_back(vaddr_t'(vd * VregWords + word));
      exp_be.push_back(be);
      exp_id.push_back(id);
      left = (left < epw) ? 0 : left - epw;
      word++;
    end
    exp_done.push_back(id);
    send_insn(op, vsew, vl, vd, id, vm, use_scalar, scalar);
  endtask

  // Wait for every expected word and done pulse, then compare in order
  task automatic check_results(string name);
    int unsigned t;
    t = 0;
    while ((got_data.size() < exp_data.size() || got_done.size() < exp_done.size())
           && t < 2000) begin
      @(posedge clk_i);
      #1;
      t++;
    end
    if (got_data.size() < exp_data.size() || got_done.size() < exp_done.size()) begin
      $display("Timeout in %s: results still missing", name);
      timeouts++;
    end
    // Room for stray duplicates to show up
    repeat (4) @(posedge clk_i);
    #1;
    if (got_data.size() != exp_data.size() || got_done.size() != exp_done.size()) begin
      $display("%s: got %0d words and %0d done pulses, expected %0d and %0d", name,
               got_data.size(), got_done.size(), exp_data.size(), exp_done.size());
      errors++;
    end
    for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
      check_word(name, exp_data[i], got_data[i]);
      check_addr(name, exp_addr[i], got_addr[i]);
      check_be(name, exp_be[i], got_be[i]);
      check_id(name, exp_id[i], got_id[i]);
    end
    for (int i = 0; i < exp_done.size() && i < got_done.size(); i++) begin
      check_id({name, " done"}, exp_done[i], got_done[i]);
    end
    exp_data.delete();
    exp_addr.delete();
    exp_be.delete();
    exp_id.delete();
    exp_done.delete();
    got_data.delete();
    got_addr.delete();
    got_be.delete();
    got_id.delete();
    got_done.delete();
  endtask

  task automatic add_ew64();
    run_insn(VADD, EW64, 16'd3, 5'd2, 3'd0, 1'b1, 1'b0, '0, '1);
    check_results("add_ew64");
  endtask

  // Tail word of 3 bytes
  task automatic xor_ew8_tail();
    run_insn(VXOR, EW8, 16'd11, 5'd5, 3'd1, 1'b1, 1'b0, '0, '1);
    check_results("xor_ew8_tail");
  endtask

  // Small vs2 elements force borrows in every lane
  task automatic sub_ew16_scalar();
    run_insn(VSUB, EW16, 16'd8, 5'd7, 3'd2, 1'b1, 1'b1, 64'hffff_ffff_ffff_0005,
             64'h0000_0003_0000_0003);
    check_results("sub_ew16_scalar");
  endtask

  task automatic and_masked();
    run_insn(VAND, EW32, 16'd5, 5'd9, 3'd3, 1'b0, 1'b0, '0, '1);
    check_results("and_masked");
  endtask

  task automatic random_grant();
    gnt_mode = GntRandom;
    run_insn(VADD, EW8, 16'd20, 5'd1, 3'd4, 1'b1, 1'b0, '0, '1);
    run_insn(VOR, EW16, 16'd9, 5'd3, 3'd5, 1'b1, 1'b1, 64'h1234, '1);
    run_insn(VSUB, EW32, 16'd6, 5'd4, 3'd6, 1'b0, 1'b0, '0, '1);
    check_results("random_grant");
    gnt_mode = GntAlways;
  endtask

  // Four long instructions fill the queue while grants are stalled
  task automatic queue_full();
    int unsigned t;
    gnt_mode = GntStall;
    for (int i = 0; i < 4; i++) begin
      run_insn(VADD, EW64, 16'd4, vreg_t'(10 + i), vid_t'(i), 1'b1, 1'b0, '0, '1);
    end
    repeat (3) @(posedge clk_i);
    #1;
    check_flag("queue_full", 1'b0, insn_ready_o);
    gnt_mode = GntAlways;
    t = 0;
    while (got_done.size() == 0 && t < 500) begin
      check_flag("queue_full", 1'b0, insn_ready_o);
      @(posedge clk_i);
      #1;
      t++;
    end
    if (got_done.size() == 0) begin
      $display("Timeout in queue_full: first instruction never completed");
      timeouts++;
    end
    check_flag("queue_full", 1'b1, insn_ready_o);
    check_results("queue_full");
  endtask

  initial begin
    rst_ni            = 1'b0;
    insn_valid_i      = 1'b0;
    op_i              = VADD;
    vsew_i            = EW8;
    vl_i              = '0;
    vd_i              = '0;
    id_i              = '0;
    vm_i              = 1'b1;
    use_scalar_i      = 1'b0;
    scalar_i          = '0;
    use_vs1_i         = 1'b0;
    operand_a_i       = '0;
    operand_a_valid_i = 1'b0;
    operand_b_i       = '0;
    operand_b_valid_i = 1'b0;
    mask_i            = '0;
    mask_valid_i      = 1'b0;
    res_gnt_i         = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    add_ew64();
    xor_ew8_tail();
    sub_ew16_scalar();
    and_masked();
    random_grant();
    queue_full();
    $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/valu_pkg.sv
source/vinsn_queue.sv
simd_alu/simd_alu.sv
source/elem_seq.sv
source/result_queue.sv
source/valu_top.sv
verif/valu_props.sv
verif/valu_tb.sv

// ==== Bender.yml ====
package:
  name: valu_lane

dependencies: {}

sources:
  # Shared package first
  - common/valu_pkg.sv
  # Lane datapath and control
  - source/vinsn_queue.sv
  - simd_alu/simd_alu.sv
  - source/elem_seq.sv
  - source/result_queue.sv
  # Top level
  - source/valu_top.sv
  # Testbench
  - target: test
    files:
      - verif/valu_props.sv
      - verif/valu_tb.sv
